// ==== verilog/pyrx_acl_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// acl receive buffer widths shared by all blocks
// packet type codes and payload packer states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package pyrx_acl_pkg;

  // one host word, four payload bytes
  localparam int word_w = 32;
  // payload length field in bytes, up to 1023
  localparam int len_w = 10;
  // 256 words in each buffer half
  localparam int addr_w_dflt = 8;

  // packet type field as carried in the header
  typedef enum logic [3:0] {
    pt_null  = 4'h0,
    pt_poll  = 4'h1,
    pt_fhs   = 4'h2,
    pt_dm1   = 4'h3,
    pt_dh1   = 4'h4,
    // sco voice types all fold in here
    pt_other = 4'h5,
    pt_aux1  = 4'h9,
    pt_dm3   = 4'ha,
    pt_dh3   = 4'hb,
    pt_dm5   = 4'he,
    pt_dh5   = 4'hf
  } acl_pktype_e;

  // byte packer
  typedef enum logic {
    pk_idle    = 1'b0,
    pk_payload = 1'b1
  } pack_state_e;

endpackage

// ==== verilog/sram256x32_1p.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single port sync sram model, one cycle read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sram256x32_1p #(
  parameter int addr_w = pyrx_acl_pkg::addr_w_dflt
) (
  input  logic                            clk_6M,
  input  logic [addr_w-1:0]               a,
  input  logic [pyrx_acl_pkg::word_w-1:0] din,
  input  logic                            we,
  input  logic                            cs,
  output logic [pyrx_acl_pkg::word_w-1:0] dout
);
  import pyrx_acl_pkg::*;

  logic [word_w-1:0] mem [2**addr_w];

  // write when selected, otherwise read into the output register
  // dout keeps the last read word while deselected
  always_ff @(posedge clk_6M)
  begin
    if (cs && we)
      mem[a] <= din;
    else if (cs)
      dout <= mem[a];
  end

  // the buffer control must raise cs together with every write
  a_we_needs_cs: assert property (@(posedge clk_6M) we |-> cs)
    else $error("sram write strobe without chip select");

endmodule

// ==== verilog/pyrx_hdr_qualify.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// header qualifier: lt address match, acl data type
// hec result hold and packet good strobe
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pyrx_hdr_qualify (
  input  logic                      clk_6M,
  input  logic                      rstz,
  input  logic                      dec_hdr_valid_p,
  input  logic [2:0]                dec_lt_addr,
  input  pyrx_acl_pkg::acl_pktype_e dec_type,
  input  logic                      dec_hecgood,
  input  logic                      dec_crcgood,
  input  logic                      dec_payload_endp,
  input  logic [2:0]                own_lt_addr,
  output logic                      ckheader_endp,
  output logic                      lt_addressed,
  output logic                      pktype_data,
  output logic                      hecgood,
  output logic                      pkt_good_endp
);
  import pyrx_acl_pkg::*;

  logic type_is_data;
  // a header has been seen and its payload has not ended yet
  logic hdr_seen;

  // acl data types only, link control and voice types never reach the buffer
  always_comb
  begin
    case (dec_type)
      pt_dm1, pt_dh1, pt_aux1,
      pt_dm3, pt_dh3,
      pt_dm5, pt_dh5: type_is_data = 1'b1;
      default:        type_is_data = 1'b0;
    endcase
  end

  // header results held until the next header
  // they become valid on the same edge as ckheader_endp
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      ckheader_endp <= 1'b0;
      lt_addressed  <= 1'b0;
      pktype_data   <= 1'b0;
      hecgood       <= 1'b0;
    end
    else
    begin
      ckheader_endp <= dec_hdr_valid_p;
      if (dec_hdr_valid_p)
      begin
        lt_addressed <= (dec_lt_addr == own_lt_addr);
        pktype_data  <= type_is_data;
        hecgood      <= dec_hecgood;
      end
    end
  end

  // payload end strobe, qualified by header and crc
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hdr_seen      <= 1'b0;
      pkt_good_endp <= 1'b0;
    end
    else
    begin
      if (dec_hdr_valid_p)
        hdr_seen <= 1'b1;
      else if (dec_payload_endp)
        hdr_seen <= 1'b0;
      // crc is only valid with the payload end pulse
      pkt_good_endp <= dec_payload_endp & hdr_seen & hecgood & lt_addressed &
                       pktype_data & dec_crcgood;
    end
  end

  // the decoder always sends a header before a payload
  a_payload_after_header: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    dec_payload_endp |-> hdr_seen
  ) else $error("payload end without a preceding header");

endmodule

// ==== verilog/pyrx_payload_pack.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload byte packer: 4 bytes per word, write
// address and strobe, payload length in bytes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pyrx_payload_pack #(
  parameter int addr_w = pyrx_acl_pkg::addr_w_dflt
) (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            dec_payload_startp,
  input  logic                            rx_byte_p,
  input  logic [7:0]                      rx_byte,
  input  logic                            dec_payload_endp,
  output logic                            lnctrl_we,
  output logic [addr_w-1:0]               lnctrl_addr,
  output logic [pyrx_acl_pkg::word_w-1:0] lnctrl_din,
  output logic [pyrx_acl_pkg::len_w-1:0]  dec_pylenByte
);
  import pyrx_acl_pkg::*;

  pack_state_e       state;
  logic [len_w-1:0]  byte_cnt;
  logic [len_w-1:0]  cnt_nxt;
  logic [word_w-1:0] word_q;
  logic [word_w-1:0] word_nxt;
  logic [1:0]        lane;
  logic              byte_take;
  logic              word_full;
  logic              pay_end;
  logic              flush;

  // byte lane inside the current word, byte 0 lands in 7:0
  assign lane      = byte_cnt[1:0];
  assign byte_take = rx_byte_p && (state == pk_payload);
  assign pay_end   = dec_payload_endp && (state == pk_payload);
  assign cnt_nxt   = byte_cnt + len_w'(byte_take);
  // fourth byte completes a word
  assign word_full = byte_take && (lane == 2'd3);
  // partial word left over at payload end, also when the last byte comes with endp
  assign flush     = pay_end && (cnt_nxt[1:0] != 2'd0);

  always_comb
  begin
    word_nxt = word_q;
    if (byte_take)
      word_nxt[{lane, 3'b000} +: 8] = rx_byte;
  end

  // control: state, byte count, write strobe, length
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      state         <= pk_idle;
      byte_cnt      <= '0;
      lnctrl_we     <= 1'b0;
      dec_pylenByte <= '0;
    end
    else
    begin
      lnctrl_we <= word_full | flush;
      if (dec_payload_startp)
      begin
        state    <= pk_payload;
        byte_cnt <= '0;
      end
      else if (pay_end)
      begin
        state         <= pk_idle;
        byte_cnt      <= cnt_nxt;
        dec_pylenByte <= cnt_nxt;
      end
      else if (byte_take)
        byte_cnt <= cnt_nxt;
    end
  end

  // word assembly and write data
  // word_q is cleared after each write so a flushed word is zero padded
  always_ff @(posedge clk_6M)
  begin
    if (dec_payload_startp || word_full || pay_end)
      word_q <= '0;
    else if (byte_take)
      word_q <= word_nxt;
    if (word_full || flush)
    begin
      lnctrl_din  <= word_nxt;
      // word index of the byte count before it advances
      lnctrl_addr <= addr_w'(byte_cnt >> 2);
    end
  end

  // bytes only arrive between payload start and end
  a_byte_in_payload: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    rx_byte_p |-> (state == pk_payload)
  ) else $error("payload byte outside payload window");

endmodule

// ==== verilog/pyrxaclbufctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// acl rx ping-pong buffer control: two sram halves
// empty flags, host read swap, flow bit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pyrxaclbufctrl #(
  parameter int addr_w = pyrx_acl_pkg::addr_w_dflt
) (
  input  logic                            clk_6M,
  input  logic                            rstz,
  input  logic                            ckheader_endp,
  input  logic                            lt_addressed,
  input  logic                            hecgood,
  input  logic                            pktype_data,
  input  logic                            pkt_good_endp,
  input  logic                            corre_trgp,
  input  logic                            connsactive,
  input  logic                            tx_packet_st_p,
  input  logic [pyrx_acl_pkg::len_w-1:0]  dec_pylenByte,
  input  logic                            bsm_valid_p,
  input  logic [addr_w-1:0]               bsm_addr,
  input  logic                            bsm_cs,
  input  logic [addr_w-1:0]               lnctrl_addr,
  input  logic [pyrx_acl_pkg::word_w-1:0] lnctrl_din,
  input  logic                            lnctrl_we,
  output logic [pyrx_acl_pkg::word_w-1:0] bsm_dout,
  output logic                            regi_aclrxbufempty
);
  import pyrx_acl_pkg::*;

  // half the host reads from
  logic              half_sel;
  // half_sel one cycle late, matches the sram read latency
  logic              rd_sel_q;
  logic              wr_half;
  logic [1:0]        empty;
  logic              wr_ok;
  logic              wr_en;
  logic              rxindicator;
  logic              hdr_ours;
  // current packet may write and commit
  logic              rx_accept;
  logic              commit;
  logic              rd_end;
  logic [len_w-1:0]  len_q [2];
  logic [len_w-1:0]  len_rd;
  logic [len_w:0]    word_cnt;
  logic [addr_w-1:0] last_addr;
  logic [word_w-1:0] sram_dout [2];

  // fill the read half first while it is empty, else the other one
  // this keeps the target stable when a read ends mid payload
  assign wr_half = empty[half_sel] ? half_sel : ~half_sel;
  // room somewhere: write half empty or read half empty
  assign wr_ok   = empty[wr_half] | empty[half_sel];
  assign wr_en   = lnctrl_we & wr_ok & rx_accept;

  // header for us with a clean hec while a receive slot is open
  assign hdr_ours = ckheader_endp & hecgood & lt_addressed & rxindicator;
  // only commit when the flow bit promised room to the sender
  assign commit   = pkt_good_endp & rx_accept & regi_aclrxbufempty;

  // last word address = ceil(len/4) - 1 of the half being read
  assign len_rd    = len_q[half_sel];
  assign word_cnt  = ({1'b0, len_rd} + (len_w + 1)'(3)) >> 2;
  assign last_addr = addr_w'(word_cnt - 1'b1);
  // read of an empty half never swaps
  assign rd_end    = bsm_valid_p & ~empty[half_sel] & (bsm_addr >= last_addr);

  for (genvar h = 0; h < 2; h++)
  begin : g_half
    logic              is_wr;
    logic [addr_w-1:0] a;
    logic              we;
    logic              cs;

    assign is_wr = (wr_half == 1'(h));
    // packer owns the write half, host owns the other
    assign a     = is_wr ? lnctrl_addr : bsm_addr;
    assign we    = is_wr & wr_en;
    assign cs    = is_wr ? wr_en : bsm_cs;

    sram256x32_1p #(
      .addr_w (addr_w)
    ) sram_i (
      .clk_6M (clk_6M),
      .a      (a),
      .din    (lnctrl_din),
      .we     (we),
      .cs     (cs),
      .dout   (sram_dout[h])
    );
  end

  assign bsm_dout = sram_dout[rd_sel_q];

  // half select, swaps at end of host read
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      half_sel <= 1'b0;
      rd_sel_q <= 1'b0;
    end
    else
    begin
      rd_sel_q <= half_sel;
      if (rd_end)
        half_sel <= ~half_sel;
    end
  end

  // receive slot indicator
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rxindicator <= 1'b0;
    else if (corre_trgp && connsactive)
      rxindicator <= 1'b1;
    else if (tx_packet_st_p)
      rxindicator <= 1'b0;
  end

  // decided at end of header, held through the payload
  // non data packets do not write, keeps poll/null off the srams
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      rx_accept <= 1'b0;
    else if (ckheader_endp)
      rx_accept <= hdr_ours & pktype_data;
  end

  // empty flags
  // read end frees the read half, commit fills the write half
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      empty <= 2'b11;
    else
    begin
      for (int h = 0; h < 2; h++)
      begin
        if (rd_end && (half_sel == 1'(h)))
          empty[h] <= 1'b1;
        else if (commit && (wr_half == 1'(h)))
          empty[h] <= 1'b0;
      end
    end
  end

  // flow bit, 1 = another payload can be taken
  // sampled at header end so it never flips in the middle of a payload
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      regi_aclrxbufempty <= 1'b1;
    else if (hdr_ours)
      regi_aclrxbufempty <= wr_ok;
  end

  // committed length per half, read back through len_rd
  always_ff @(posedge clk_6M)
  begin
    if (commit)
      len_q[wr_half] <= dec_pylenByte;
  end

  // room promised at header time must still exist at commit
  a_commit_has_room: assert property (
    @(posedge clk_6M) disable iff (!rstz)
    commit |-> wr_ok
  ) else $error("packet committed with both halves full");

endmodule

// ==== verilog/pyrx_acl_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// acl rx payload buffer top: header qualifier,
// byte packer and ping-pong buffer control
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pyrx_acl_top #(
  parameter int addr_w = pyrx_acl_pkg::addr_w_dflt
) (
  input  logic                            clk_6M,
  input  logic                            rstz,
  // decoder header side
  input  logic                            dec_hdr_valid_p,
  input  logic [2:0]                      dec_lt_addr,
  input  pyrx_acl_pkg::acl_pktype_e       dec_type,
  input  logic                            dec_hecgood,
  input  logic                            dec_crcgood,
  input  logic [2:0]                      own_lt_addr,
  // decoder payload side
  input  logic                            dec_payload_startp,
  input  logic                            rx_byte_p,
  input  logic [7:0]                      rx_byte,
  input  logic                            dec_payload_endp,
  // correlator and slot timing
  input  logic                            corre_trgp,
  input  logic                            connsactive,
  input  logic                            tx_packet_st_p,
  // host read port
  input  logic                            bsm_cs,
  input  logic [addr_w-1:0]               bsm_addr,
  input  logic                            bsm_valid_p,
  output logic [pyrx_acl_pkg::word_w-1:0] bsm_dout,
  output logic                            regi_aclrxbufempty
);
  import pyrx_acl_pkg::*;

  logic              ckheader_endp;
  logic              lt_addressed;
  logic              pktype_data;
  logic              hecgood;
  logic              pkt_good_endp;
  logic              lnctrl_we;
  logic [addr_w-1:0] lnctrl_addr;
  logic [word_w-1:0] lnctrl_din;
  logic [len_w-1:0]  dec_pylenByte;

  // header checks run alongside the payload packing
  pyrx_hdr_qualify hdr_qualify_i (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .dec_hdr_valid_p  (dec_hdr_valid_p),
    .dec_lt_addr      (dec_lt_addr),
    .dec_type         (dec_type),
    .dec_hecgood      (dec_hecgood),
    .dec_crcgood      (dec_crcgood),
    .dec_payload_endp (dec_payload_endp),
    .own_lt_addr      (own_lt_addr),
    .ckheader_endp    (ckheader_endp),
    .lt_addressed     (lt_addressed),
    .pktype_data      (pktype_data),
    .hecgood          (hecgood),
    .pkt_good_endp    (pkt_good_endp)
  );

  pyrx_payload_pack #(
    .addr_w (addr_w)
  ) payload_pack_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .dec_payload_startp (dec_payload_startp),
    .rx_byte_p          (rx_byte_p),
    .rx_byte            (rx_byte),
    .dec_payload_endp   (dec_payload_endp),
    .lnctrl_we          (lnctrl_we),
    .lnctrl_addr        (lnctrl_addr),
    .lnctrl_din         (lnctrl_din),
    .dec_pylenByte      (dec_pylenByte)
  );

  // commit decision and host side reads
  pyrxaclbufctrl #(
    .addr_w (addr_w)
  ) bufctrl_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .ckheader_endp      (ckheader_endp),
    .lt_addressed       (lt_addressed),
    .hecgood            (hecgood),
    .pktype_data        (pktype_data),
    .pkt_good_endp      (pkt_good_endp),
    .corre_trgp         (corre_trgp),
    .connsactive        (connsactive),
    .tx_packet_st_p     (tx_packet_st_p),
    .dec_pylenByte      (dec_pylenByte),
    .bsm_valid_p        (bsm_valid_p),
    .bsm_addr           (bsm_addr),
    .bsm_cs             (bsm_cs),
    .lnctrl_addr        (lnctrl_addr),
    .lnctrl_din         (lnctrl_din),
    .lnctrl_we          (lnctrl_we),
    .bsm_dout           (bsm_dout),
    .regi_aclrxbufempty (regi_aclrxbufempty)
  );

endmodule

// ==== dv/pyrx_acl_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// acl rx buffer testbench: trace driven stimulus,
// buffer/flow reference model, checks and timeout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pyrx_acl_tb;
  import pyrx_acl_pkg::*;

  localparam int addr_w = addr_w_dflt;
  // widest random idle gap between payload bytes
  localparam int max_gap = 3;
  localparam logic [2:0] own_lt = 3'd1;

  logic              clk_6M;
  logic              rstz;
  logic              dec_hdr_valid_p;
  logic [2:0]        dec_lt_addr;
  acl_pktype_e       dec_type;
  logic              dec_hecgood;
  logic              dec_crcgood;
  logic              dec_payload_startp;
  logic              rx_byte_p;
  logic [7:0]        rx_byte;
  logic              dec_payload_endp;
  logic              corre_trgp;
  logic              connsactive;
  logic              tx_packet_st_p;
  logic              bsm_cs;
  logic [addr_w-1:0] bsm_addr;
  logic              bsm_valid_p;
  logic [word_w-1:0] bsm_dout;
  logic              regi_aclrxbufempty;

  // reference model: empty flags, read half, flow bit, committed words
  bit [1:0]          m_empty;
  bit                m_sel;
  bit                m_flow;
  int                m_cnt [2];
  logic [31:0]       m_word [2][64];

  int                fd;
  int                mismatch_cnt;
  int                other_cnt;
  int                check_cnt;
  int                cycle_cnt;
  int                limit_cycles;
  bit                limit_ready;
  // payload bytes of the packet being driven
  logic [7:0]        pkt_q [$];

  pyrx_acl_top #(
    .addr_w (addr_w)
  ) dut_i (
    .clk_6M             (clk_6M),
    .rstz               (rstz),
    .dec_hdr_valid_p    (dec_hdr_valid_p),
    .dec_lt_addr        (dec_lt_addr),
    .dec_type           (dec_type),
    .dec_hecgood        (dec_hecgood),
    .dec_crcgood        (dec_crcgood),
    .own_lt_addr        (own_lt),
    .dec_payload_startp (dec_payload_startp),
    .rx_byte_p          (rx_byte_p),
    .rx_byte            (rx_byte),
    .dec_payload_endp   (dec_payload_endp),
    .corre_trgp         (corre_trgp),
    .connsactive        (connsactive),
    .tx_packet_st_p     (tx_packet_st_p),
    .bsm_cs             (bsm_cs),
    .bsm_addr           (bsm_addr),
    .bsm_valid_p        (bsm_valid_p),
    .bsm_dout           (bsm_dout),
    .regi_aclrxbufempty (regi_aclrxbufempty)
  );

  // 100 ns clock
  initial
  begin
    clk_6M = 1'b0;
    forever #50 clk_6M = ~clk_6M;
  end

  // acl data types per the air format, everything else is link control or voice
  function automatic bit is_acl_data(input acl_pktype_e t);
    case (t)
      pt_dm1, pt_dh1, pt_aux1, pt_dm3, pt_dh3, pt_dm5, pt_dh5: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // first pass over the trace, sizes the run for the timeout
  task automatic scan_trace(output int n_pkt, output int n_byte, output int n_word);
    int sfd;
    int rc;
    int lt;
    int typ;
    int hec;
    int crc;
    int len;
    int v;
    string kw;
    string name;
    logic [8*128-1:0] line_buf;
    n_pkt  = 0;
    n_byte = 0;
    n_word = 0;
    sfd = $fopen("dv/pyrx_acl_trace.txt", "r");
    if (sfd == 0)
      return;
    while ($fscanf(sfd, "%s", kw) == 1)
    begin
      if (kw == "pkt")
      begin
        rc = $fscanf(sfd, "%s %d %h %d %d %d", name, lt, typ, hec, crc, len);
        n_pkt++;
        n_byte += len;
        for (int i = 0; i < len; i++)
          rc = $fscanf(sfd, "%h", v);
      end
      else if (kw == "read")
      begin
        rc = $fscanf(sfd, "%s %d", name, v);
        n_word += v;
        rc = $fgets(line_buf, sfd);
      end
      else
        rc = $fgets(line_buf, sfd);
    end
    $fclose(sfd);
  endtask

  // one packet: slot open, header, payload bytes with random gaps, end pulse
  task automatic drive_packet(input logic [2:0] lt, input logic [3:0] typ,
                              input bit hec, input bit crc);
    int gap;
    @(posedge clk_6M);
    corre_trgp <= 1'b1;
    @(posedge clk_6M);
    corre_trgp      <= 1'b0;
    dec_hdr_valid_p <= 1'b1;
    dec_lt_addr     <= lt;
    dec_type        <= acl_pktype_e'(typ);
    dec_hecgood     <= hec;
    @(posedge clk_6M);
    dec_hdr_valid_p <= 1'b0;
    @(posedge clk_6M);
    dec_payload_startp <= 1'b1;
    @(posedge clk_6M);
    dec_payload_startp <= 1'b0;
    for (int i = 0; i < pkt_q.size(); i++)
    begin
      gap = $urandom % (max_gap + 1);
      repeat (gap) @(posedge clk_6M);
      @(posedge clk_6M);
      rx_byte_p <= 1'b1;
      rx_byte   <= pkt_q[i];
      @(posedge clk_6M);
      rx_byte_p <= 1'b0;
    end
    @(posedge clk_6M);
    dec_payload_endp <= 1'b1;
    dec_crcgood      <= crc;
    @(posedge clk_6M);
    dec_payload_endp <= 1'b0;
    // flush write and commit land two edges after the end pulse
    repeat (2) @(posedge clk_6M);
    tx_packet_st_p <= 1'b1;
    @(posedge clk_6M);
    tx_packet_st_p <= 1'b0;
  endtask

  // flow decided at our header, commit only with room promised
  task automatic model_packet(input logic [2:0] lt, input logic [3:0] typ,
                              input bit hec, input bit crc);
    bit ours;
    bit wh;
    logic [31:0] w;
    ours = hec && (lt == own_lt);
    // the read half is filled first while it is empty
    wh = m_empty[m_sel] ? m_sel : !m_sel;
    if (ours)
      m_flow = m_empty[wh] | m_empty[m_sel];
    if (ours && is_acl_data(acl_pktype_e'(typ)) && crc && m_flow)
    begin
      m_empty[wh] = 1'b0;
      m_cnt[wh]   = (pkt_q.size() + 3) / 4;
      for (int k = 0; k < m_cnt[wh]; k++)
      begin
        // little endian, unused top bytes stay zero
        w = '0;
        for (int j = 0; j < 4; j++)
          if (4 * k + j < pkt_q.size())
            w = w | ({24'h0, pkt_q[4 * k + j]} << (8 * j));
        m_word[wh][k] = w;
      end
    end
  endtask

  // host read of n words, last address carries bsm_valid_p
  task automatic read_check(input string name, input int n);
    logic [31:0] exp_w;
    int rc;
    assert (!m_empty[m_sel])
      else begin
        other_cnt++;
        $display("%s: host read of a half that holds no committed packet", name);
      end
    assert (m_cnt[m_sel] == n)
      else begin
        other_cnt++;
        $display("%s: trace expects %0d words but model holds %0d", name, n, m_cnt[m_sel]);
      end
    for (int i = 0; i < n; i++)
    begin
      rc = $fscanf(fd, "%h", exp_w);
      @(posedge clk_6M);
      bsm_cs      <= 1'b1;
      bsm_addr    <= addr_w'(i);
      bsm_valid_p <= (i == n - 1);
      @(posedge clk_6M);
      bsm_cs      <= 1'b0;
      bsm_valid_p <= 1'b0;
      // one cycle read latency, sample mid cycle
      @(negedge clk_6M);
      check_cnt++;
      assert (m_word[m_sel][i] === exp_w)
        else begin
          other_cnt++;
          $display("%s: model word %0d is %h but trace has %h", name, i, m_word[m_sel][i],
                   exp_w);
        end
      assert (bsm_dout === exp_w)
        else begin
          mismatch_cnt++;
          $display("Mismatch %s word %0d: expected %h actual %h", name, i, exp_w, bsm_dout);
        end
    end
    // read end frees the half and swaps
    m_empty[m_sel] = 1'b1;
    m_sel = !m_sel;
  endtask

  task automatic flow_check(input string name, input bit exp);
    @(negedge clk_6M);
    check_cnt++;
    assert (m_flow == exp)
      else begin
        other_cnt++;
        $display("%s: model flow bit %0d disagrees with trace %0d", name, m_flow, exp);
      end
    assert (regi_aclrxbufempty === exp)
      else begin
        mismatch_cnt++;
        $display("Mismatch %s flow: expected %0d actual %0d", name, exp, regi_aclrxbufempty);
      end
  endtask

  // run limit from trace size
  initial
  begin
    wait (limit_ready);
    while (cycle_cnt < limit_cycles)
    begin
      @(posedge clk_6M);
      cycle_cnt++;
    end
    $display("timeout: trace not finished after %0d cycles", limit_cycles);
    $display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
             other_cnt + 1);
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    int n_pkt;
    int n_byte;
    int n_word;
    int rc;
    int lt;
    int typ;
    int hec;
    int crc;
    int len;
    int v;
    string kw;
    string name;
    logic [8*128-1:0] line_buf;
    rstz               = 1'b0;
    dec_hdr_valid_p    = 1'b0;
    dec_lt_addr        = 3'd0;
    dec_type           = pt_null;
    dec_hecgood        = 1'b0;
    dec_crcgood        = 1'b0;
    dec_payload_startp = 1'b0;
    rx_byte_p          = 1'b0;
    rx_byte            = 8'h00;
    dec_payload_endp   = 1'b0;
    corre_trgp         = 1'b0;
    connsactive        = 1'b1;
    tx_packet_st_p     = 1'b0;
    bsm_cs             = 1'b0;
    bsm_addr           = '0;
    bsm_valid_p        = 1'b0;
    // model after reset: both halves empty, room, half 0
    m_empty = 2'b11;
    m_sel   = 1'b0;
    m_flow  = 1'b1;
    rc = $urandom(89411);
    scan_trace(n_pkt, n_byte, n_word);
    limit_cycles = 5 + n_pkt * 20 + n_byte * (max_gap + 2) + n_word * 4 + 300;
    limit_ready  = 1'b1;
    repeat (5) @(posedge clk_6M);
    rstz <= 1'b1;
    @(posedge clk_6M);
    fd = $fopen("dv/pyrx_acl_trace.txt", "r");
    if (fd == 0)
    begin
      other_cnt++;
      $display("could not open the trace file dv/pyrx_acl_trace.txt");
    end
    else
    begin
      while ($fscanf(fd, "%s", kw) == 1)
      begin
        if (kw == "#")
          rc = $fgets(line_buf, fd);
        else if (kw == "pkt")
        begin
          rc = $fscanf(fd, "%s %d %h %d %d %d", name, lt, typ, hec, crc, len);
          pkt_q.delete();
          for (int i = 0; i < len; i++)
          begin
            rc = $fscanf(fd, "%h", v);
            pkt_q.push_back(v[7:0]);
          end
          drive_packet(lt[2:0], typ[3:0], hec[0], crc[0]);
          model_packet(lt[2:0], typ[3:0], hec[0], crc[0]);
        end
        else if (kw == "read")
        begin
          rc = $fscanf(fd, "%s %d", name, v);
          read_check(name, v);
        end
        else if (kw == "flow")
        begin
          rc = $fscanf(fd, "%s %d", name, v);
          flow_check(name, v[0]);
        end
        else
        begin
          other_cnt++;
          $display("unknown trace command %s", kw);
          rc = $fgets(line_buf, fd);
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, mismatches %0d, other errors %0d", check_cnt, mismatch_cnt,
             other_cnt);
    if (mismatch_cnt + other_cnt == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== dv/pyrx_acl_trace.txt ====
# pkt  <name> <lt> <type hex> <hec> <crc> <len dec> <payload bytes hex>
# read <name> <words> <expected words hex> ; flow <name> <expected flow bit>
# own lt address is 1
flow reset 1
# good dm1 into the empty buffer, partial last word
pkt good_a 1 3 1 1 5 11 22 33 44 55
flow good_a 1
read good_a 2 44332211 00000055
# back pressure, two packets fill both halves
pkt bp_b 1 4 1 1 4 a0 a1 a2 a3
flow bp_b 1
pkt bp_c 1 a 1 1 6 b0 b1 b2 b3 b4 b5
flow bp_c 1
# third payload is dropped
pkt bp_d 1 b 1 1 4 c0 c1 c2 c3
flow bp_d 0
read bp_b 1 a3a2a1a0
# swap to the other half
read bp_c 2 b3b2b1b0 0000b5b4
# flow only moves at the next header
flow bp_drained 0
pkt bp_e 1 3 1 1 2 9a 9b
flow bp_e 1
read bp_e 1 00009b9a
# rejected packets, bad crc
pkt rej_crc 1 3 1 0 3 d0 d1 d2
flow rej_crc 1
# bad hec
pkt rej_hec 1 3 0 1 2 e0 e1
# wrong lt address
pkt rej_lt 2 3 1 1 2 e2 e3
# poll carries no data
pkt rej_poll 1 1 1 1 0
flow rej_poll 1
pkt after_rej 1 e 1 1 1 f1
flow after_rej 1
read after_rej 1 000000f1
# lengths 4 and 17 across both halves
pkt len4 1 f 1 1 4 01 02 03 04
pkt len17 1 9 1 1 17 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20
flow len17 1
read len4 1 04030201
read len17 5 13121110 17161514 1b1a1918 1f1e1d1c 00000020
flow tail 1

// ==== pyrx_acl_top.f ====
verilog/pyrx_acl_pkg.sv
verilog/sram256x32_1p.sv
verilog/pyrx_hdr_qualify.sv
verilog/pyrx_payload_pack.sv
verilog/pyrxaclbufctrl.sv
verilog/pyrx_acl_top.sv
dv/pyrx_acl_tb.sv

// ==== Bender.yml ====
package:
  name: pyrx_acl

sources:
  # design, in compile order
  - verilog/pyrx_acl_pkg.sv
  - verilog/sram256x32_1p.sv
  - verilog/pyrx_hdr_qualify.sv
  - verilog/pyrx_payload_pack.sv
  - verilog/pyrxaclbufctrl.sv
  - verilog/pyrx_acl_top.sv

  # testbench, top module pyrx_acl_tb
  - target: test
    files:
      - dv/pyrx_acl_tb.sv
